// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module state_cache_tb -o state_cache_sim

./obj_dir/state_cache_sim | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// ==== sources.f ====
+incdir+verilog
verilog/state_cache_pkg.sv
verilog/table_update_if.sv
verilog/key_table.sv
verilog/sync_fifo.sv
verilog/lookup_resolver.sv
verilog/state_cache.sv
tests/state_cache_assert.sv
tests/state_cache_tb.sv

// ==== tests/state_cache_assert.sv ====
`timescale 1ns/1ps

module state_cache_assert
    import state_cache_pkg::*;
(
    input logic clk,
    input logic htable_srst,
    input logic i_lookup_req,
    input logic o_lookup_rdy,
    input logic o_lookup_ack,
    input logic o_lookup_valid,
    input logic upd_req,
    input id_t  upd_id
);

    // ----------------------------------------
    // Lookup result timing
    // ----------------------------------------
    ack_after_accept: assert property (@(posedge clk) disable iff (htable_srst)
        (i_lookup_req && o_lookup_rdy) |-> ##2 o_lookup_ack)
        else $error("lookup ack missing two cycles after acceptance");

    // No ack without a lookup accepted two cycles earlier
    ack_has_accept: assert property (@(posedge clk) disable iff (htable_srst)
        o_lookup_ack |-> $past(i_lookup_req && o_lookup_rdy, 2))
        else $error("lookup ack without a matching acceptance");

    valid_with_ack: assert property (@(posedge clk) disable iff (htable_srst)
        o_lookup_valid |-> o_lookup_ack)
        else $error("lookup valid high without ack");

    // ----------------------------------------
    // Table writes
    // ----------------------------------------
    upd_id_known: assert property (@(posedge clk) disable iff (htable_srst)
        upd_req |-> !$isunknown(upd_id))
        else $error("table write with unknown ID");

endmodule : state_cache_assert

bind state_cache state_cache_assert assert0 (
    .clk            (clk),
    .htable_srst    (htable_srst),
    .i_lookup_req   (i_lookup_req),
    .o_lookup_rdy   (o_lookup_rdy),
    .o_lookup_ack   (o_lookup_ack),
    .o_lookup_valid (o_lookup_valid),
    .upd_req        (upd_if.upd_req),
    .upd_id         (upd_if.upd_id)
);

// ==== tests/state_cache_tb.sv ====
`timescale 1ns/1ps
`include "state_cache_cfg.svh"

module state_cache_tb
    import state_cache_pkg::*;
();

    localparam int NUM_IDS   = 2 ** `STATE_CACHE_ID_WID;
    localparam int MAX_ROWS  = 48;
    localparam int OP_LOOKUP = 0;
    localparam int OP_RAND   = 1;
    localparam int OP_DELETE = 2;
    localparam int OP_FILL   = 3;
    // Expected ID codes next to a plain ID
    localparam int EXP_NT    = NUM_IDS;
    localparam int EXP_MODEL = -1;

    logic  clk;
    logic  htable_srst;
    logic  i_lookup_req;
    key_t  i_lookup_key;
    logic  i_delete_req;
    id_t   i_delete_id;
    logic  i_cnt_clear;
    logic  o_lookup_rdy;
    logic  o_lookup_ack;
    logic  o_lookup_valid;
    logic  o_lookup_new;
    id_t   o_lookup_id;
    logic  o_delete_rdy;
    logic  o_init_done;
    fill_t o_fill;
    cnt_t  o_cnt_req;
    cnt_t  o_cnt_existing;
    cnt_t  o_cnt_new;
    cnt_t  o_cnt_not_tracked;

    int          cycle;
    int          max_cycles;
    int          errors;
    int          checks;
    int          init_wait;
    logic [31:0] lcg_state;

    // Stimulus table: operation, key or ID, gap cycles, expected ID
    int n_rows;
    int row_op  [MAX_ROWS];
    int row_arg [MAX_ROWS];
    int row_gap [MAX_ROWS];
    int row_exp [MAX_ROWS];

    // Reference model
    logic tracked [256];
    int   map_id  [256];
    int   free_q  [$];
    int   m_fill;
    int   m_req;
    int   m_existing;
    int   m_new;
    int   m_nt;

    // Results still outstanding, oldest first
    logic exp_valid [$];
    logic exp_new   [$];
    int   exp_id    [$];
    int   exp_cyc   [$];

    state_cache dut0 (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void add_row(input int op, input int arg, input int gap, input int exp);
        row_op[n_rows]  = op;
        row_arg[n_rows] = arg;
        row_gap[n_rows] = gap;
        row_exp[n_rows] = exp;
        n_rows++;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_table();
        add_row(OP_LOOKUP, 'h10, 1, 0);
        add_row(OP_LOOKUP, 'h11, 1, 1);
        add_row(OP_LOOKUP, 'h12, 1, 2);
        add_row(OP_LOOKUP, 'h11, 2, 1);
        add_row(OP_FILL, 0, 0, 0);
        // Same new key in two consecutive cycles
        add_row(OP_LOOKUP, 'h20, 0, 3);
        add_row(OP_LOOKUP, 'h20, 2, 3);
        add_row(OP_FILL, 0, 0, 0);
        for (int k = 0; k < 12; k++) begin
            add_row(OP_LOOKUP, 'h30 + k, 0, 4 + k);
        end
        // Pool exhausted
        add_row(OP_LOOKUP, 'h40, 2, EXP_NT);
        add_row(OP_DELETE, 5, 2, 0);
        add_row(OP_LOOKUP, 'h41, 2, 5);
        add_row(OP_DELETE, 7, 2, 0);
        add_row(OP_LOOKUP, 'h31, 2, 7);
        add_row(OP_FILL, 0, 0, 0);
        add_row(OP_DELETE, 0, 2, 0);
        for (int k = 0; k < 8; k++) begin
            add_row(OP_RAND, 0, 0, EXP_MODEL);
        end
        add_row(OP_FILL, 0, 0, 0);
    endtask

    // Model update at acceptance, table column overrides the model
    task automatic predict_lookup(input key_t key, input int exp);
        logic v;
        logic n;
        int   id;
        m_req++;
        if (tracked[key]) begin
            v = 1'b1;
            n = 1'b0;
            id = map_id[key];
            m_existing++;
        end else if (free_q.size() > 0) begin
            v = 1'b1;
            n = 1'b1;
            id = free_q.pop_front();
            tracked[key] = 1'b1;
            map_id[key] = id;
            m_new++;
            m_fill++;
        end else begin
            v = 1'b0;
            n = 1'b0;
            id = 0;
            m_nt++;
        end
        if (exp != EXP_MODEL) begin
            v = (exp != EXP_NT);
            id = v ? exp : 0;
        end
        exp_valid.push_back(v);
        exp_new.push_back(n);
        exp_id.push_back(id);
        exp_cyc.push_back(cycle + 2);
    endtask

    task automatic run_lookup(input key_t key, input int exp, input int gap);
        i_lookup_req = 1'b1;
        i_lookup_key = key;
        while (!o_lookup_rdy) begin
            @(negedge clk);
        end
        predict_lookup(key, exp);
        @(negedge clk);
        i_lookup_req = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic run_delete(input id_t id, input int gap);
        i_delete_req = 1'b1;
        i_delete_id  = id;
        while (!o_delete_rdy) begin
            @(negedge clk);
        end
        for (int k = 0; k < 256; k++) begin
            if (tracked[k] && map_id[k] == id) begin
                tracked[k] = 1'b0;
            end
        end
        free_q.push_back(id);
        m_fill--;
        @(negedge clk);
        i_delete_req = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // Drain outstanding results, then let fill and counters settle
    task automatic wait_idle();
        while (exp_valid.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // ----------------------------------------
    // Result monitor and timeout
    // ----------------------------------------
    always @(negedge clk) begin : result_monitor
        logic v;
        if (o_lookup_ack) begin
            if (exp_valid.size() == 0) begin
                $display("Lookup result at %0t ns with no lookup outstanding", $time);
                errors++;
            end else begin
                v = exp_valid.pop_front();
                check_val("o_lookup_valid", o_lookup_valid, v);
                check_val("o_lookup_new", o_lookup_new, exp_new.pop_front());
                if (v) begin
                    check_val("o_lookup_id", o_lookup_id, exp_id[0]);
                end
                void'(exp_id.pop_front());
                check_val("o_lookup_ack cycle", cycle, exp_cyc.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Run stopped by timeout after %0d cycles", cycle);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        htable_srst  = 1'b1;
        i_lookup_req = 1'b0;
        i_lookup_key = '0;
        i_delete_req = 1'b0;
        i_delete_id  = '0;
        i_cnt_clear  = 1'b0;
        cycle        = 0;
        errors       = 0;
        checks       = 0;
        n_rows       = 0;
        lcg_state    = 32'h2e51ac51;
        m_fill       = 0;
        m_req        = 0;
        m_existing   = 0;
        m_new        = 0;
        m_nt         = 0;
        for (int k = 0; k < 256; k++) begin
            tracked[k] = 1'b0;
        end
        for (int k = 0; k < NUM_IDS; k++) begin
            free_q.push_back(k);
        end
        load_table();
        max_cycles = n_rows * 8 + 400;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val("o_lookup_ack", o_lookup_ack, 0);
        check_val("o_lookup_valid", o_lookup_valid, 0);
        check_val("o_delete_rdy", o_delete_rdy, 0);
        check_val("o_init_done", o_init_done, 0);
        check_val("o_lookup_rdy", o_lookup_rdy, 0);
        htable_srst = 1'b0;

        init_wait = 0;
        while (!o_init_done) begin
            @(negedge clk);
            init_wait++;
        end
        check_val("init cycles", init_wait, 256);

        for (int r = 0; r < n_rows; r++) begin
            case (row_op[r])
                OP_LOOKUP: run_lookup(key_t'(row_arg[r]), row_exp[r], row_gap[r]);
                OP_RAND: begin
                    lcg_state = lcg_next(lcg_state);
                    run_lookup(key_t'({4'h3, lcg_state[19:16]}), row_exp[r], row_gap[r]);
                end
                OP_DELETE: run_delete(id_t'(row_arg[r]), row_gap[r]);
                default: begin
                    wait_idle();
                    check_val("o_fill", o_fill, m_fill);
                end
            endcase
        end

        wait_idle();
        check_val("o_fill", o_fill, m_fill);
        check_val("o_cnt_req", o_cnt_req, m_req);
        check_val("o_cnt_existing", o_cnt_existing, m_existing);
        check_val("o_cnt_new", o_cnt_new, m_new);
        check_val("o_cnt_not_tracked", o_cnt_not_tracked, m_nt);

        i_cnt_clear = 1'b1;
        @(negedge clk);
        i_cnt_clear = 1'b0;
        check_val("o_cnt_req", o_cnt_req, 0);
        check_val("o_cnt_existing", o_cnt_existing, 0);
        check_val("o_cnt_new", o_cnt_new, 0);
        check_val("o_cnt_not_tracked", o_cnt_not_tracked, 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : state_cache_tb

// ==== verilog/key_table.sv ====
`timescale 1ns/1ps
`include "state_cache_cfg.svh"

module key_table
    import state_cache_pkg::*;
(
    input  logic          clk,
    input  logic          htable_srst,

    // Lookup request
    input  logic          i_lookup_req,
    input  key_t          i_lookup_key,
    output logic          o_lookup_rdy,

    // Read result towards the resolver
    output logic          o_rd_ack,
    output logic          o_rd_hit,
    output id_t           o_rd_id,

    // Table writes
    table_update_if.tbl   upd
);

    localparam int NUM_KEYS = 2 ** `STATE_CACHE_KEY_WID;
    localparam int NUM_IDS  = 2 ** `STATE_CACHE_ID_WID;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    // Forward map, indexed directly by key
    logic entry_valid [NUM_KEYS];
    id_t  entry_id    [NUM_KEYS];

    // Reverse map, ID back to its key
    key_t reverse [NUM_IDS];

    logic init_done;
    key_t init_key;

    logic s1_valid;
    key_t s1_key;

    key_t del_key;

    // ----------------------------------------
    // Init sweep
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            init_done <= 1'b0;
            init_key  <= '0;
        end else if (!init_done) begin
            init_key <= init_key + 1'b1;
            // Last entry cleared this cycle
            if (init_key == key_t'(NUM_KEYS - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    assign o_lookup_rdy = init_done;

    // ----------------------------------------
    // Table write port
    // ----------------------------------------
    // Entry owned by the ID being deleted
    assign del_key = reverse[upd.upd_id];

    always_ff @(posedge clk) begin
        if (!init_done) begin
            entry_valid[init_key] <= 1'b0;
        end else if (upd.upd_req) begin
            if (upd.upd_insert) begin
                entry_valid[upd.upd_key] <= 1'b1;
            end else begin
                entry_valid[del_key] <= 1'b0;
            end
        end
    end

    // ID payload and reverse map only change on insert
    always_ff @(posedge clk) begin
        if (upd.upd_req && upd.upd_insert) begin
            entry_id[upd.upd_key] <= upd.upd_id;
            reverse[upd.upd_id]   <= upd.upd_key;
        end
    end

    // ----------------------------------------
    // Lookup pipeline
    // ----------------------------------------
    // Stage 1 captures the request, stage 2 registers the entry
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            s1_valid <= 1'b0;
            o_rd_ack <= 1'b0;
            o_rd_hit <= 1'b0;
        end else begin
            s1_valid <= i_lookup_req && init_done;
            o_rd_ack <= s1_valid;
            o_rd_hit <= s1_valid && entry_valid[s1_key];
        end
    end

    always_ff @(posedge clk) begin
        s1_key  <= i_lookup_key;
        o_rd_id <= entry_id[s1_key];
    end

endmodule : key_table

// ==== verilog/lookup_resolver.sv ====
`timescale 1ns/1ps
`include "state_cache_cfg.svh"

module lookup_resolver
    import state_cache_pkg::*;
(
    input  logic            clk,
    input  logic            htable_srst,

    // Accepted lookup
    input  logic            i_lookup_accept,
    input  key_t            i_lookup_key,

    // Table read result
    input  logic            i_rd_ack,
    input  logic            i_rd_hit,
    input  id_t             i_rd_id,

    // Context FIFO
    input  lookup_ctxt_t    i_ctxt,
    output logic            o_ctxt_wr,
    output lookup_ctxt_t    o_ctxt,

    // ID free list
    input  id_t             i_id_free,
    input  logic            i_id_empty,
    output logic            o_id_pop,
    output logic            o_id_push,
    output id_t             o_id_push_data,

    // Delete by ID
    input  logic            i_delete_req,
    input  id_t             i_delete_id,
    output logic            o_delete_rdy,

    input  logic            i_cnt_clear,

    // Lookup result
    output logic            o_lookup_ack,
    output logic            o_lookup_valid,
    output logic            o_lookup_new,
    output id_t             o_lookup_id,

    // Status
    output fill_t           o_fill,
    output cnt_t            o_cnt_req,
    output cnt_t            o_cnt_existing,
    output cnt_t            o_cnt_new,
    output cnt_t            o_cnt_not_tracked,

    table_update_if.resolver upd
);

    localparam int NUM_IDS = 2 ** `STATE_CACHE_ID_WID;

    // Counter slots
    localparam int NUM_CNT         = 4;
    localparam int CNT_REQ         = 0;
    localparam int CNT_EXISTING    = 1;
    localparam int CNT_NEW         = 2;
    localparam int CNT_NOT_TRACKED = 3;

    logic               last_key_valid;
    key_t               last_key;
    logic               last_valid;
    id_t                last_id;
    logic               b2b_hit;
    logic               insert_req;
    logic               delete_accept;
    logic               id_init_done;
    id_t                id_init_cnt;
    fill_t              fill;
    logic [NUM_CNT-1:0] cnt_evt;
    cnt_t               cnt [NUM_CNT];

    // ----------------------------------------
    // Lookup context
    // ----------------------------------------
    assign o_ctxt_wr           = i_lookup_accept;
    assign o_ctxt.key          = i_lookup_key;
    assign o_ctxt.back_to_back = last_key_valid && (i_lookup_key == last_key);

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            last_key_valid <= 1'b0;
        end else if (i_lookup_accept) begin
            last_key_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_lookup_accept) begin
            last_key <= i_lookup_key;
        end
    end

    // Previous cycle's result, valid only if it came right before
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            last_valid <= 1'b0;
        end else begin
            last_valid <= o_lookup_ack && o_lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_lookup_ack) begin
            last_id <= o_lookup_id;
        end
    end

    // ----------------------------------------
    // Result selection
    // ----------------------------------------
    // Insert of the previous key is not yet visible in the table
    assign b2b_hit    = i_ctxt.back_to_back && last_valid;
    assign insert_req = i_rd_ack && !i_rd_hit && !b2b_hit && !i_id_empty;

    always_comb begin
        o_lookup_valid = 1'b0;
        o_lookup_new   = 1'b0;
        o_lookup_id    = '0;
        if (i_rd_ack) begin
            if (i_rd_hit) begin
                o_lookup_valid = 1'b1;
                o_lookup_id    = i_rd_id;
            end else if (b2b_hit) begin
                o_lookup_valid = 1'b1;
                o_lookup_id    = last_id;
            end else if (!i_id_empty) begin
                o_lookup_valid = 1'b1;
                o_lookup_new   = 1'b1;
                o_lookup_id    = i_id_free;
            end
        end
    end

    assign o_lookup_ack = i_rd_ack;

    // ----------------------------------------
    // ID free list
    // ----------------------------------------
    // Fill the pool with IDs 0 upwards after reset
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            id_init_done <= 1'b0;
            id_init_cnt  <= '0;
        end else if (!id_init_done) begin
            id_init_cnt <= id_init_cnt + 1'b1;
            if (id_init_cnt == id_t'(NUM_IDS - 1)) begin
                id_init_done <= 1'b1;
            end
        end
    end

    // Inserts win the table write port
    assign o_delete_rdy  = id_init_done && !insert_req;
    assign delete_accept = i_delete_req && o_delete_rdy;

    assign o_id_pop       = insert_req;
    assign o_id_push      = !id_init_done || delete_accept;
    assign o_id_push_data = id_init_done ? i_delete_id : id_init_cnt;

    // Table write
    assign upd.upd_req    = insert_req || delete_accept;
    assign upd.upd_insert = insert_req;
    assign upd.upd_key    = i_ctxt.key;
    assign upd.upd_id     = insert_req ? i_id_free : i_delete_id;

    // ----------------------------------------
    // Fill and statistics
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            fill <= '0;
        end else if (insert_req) begin
            fill <= fill + 1'b1;
        end else if (delete_accept) begin
            fill <= fill - 1'b1;
        end
    end

    assign o_fill = fill;

    // Events registered once, counted a cycle after the ack
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            cnt_evt <= '0;
        end else begin
            cnt_evt[CNT_REQ]         <= o_lookup_ack;
            cnt_evt[CNT_EXISTING]    <= o_lookup_ack && o_lookup_valid && !o_lookup_new;
            cnt_evt[CNT_NEW]         <= insert_req;
            cnt_evt[CNT_NOT_TRACKED] <= o_lookup_ack && !o_lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (htable_srst || i_cnt_clear) begin
                cnt[i] <= '0;
            end else if (cnt_evt[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign o_cnt_req         = cnt[CNT_REQ];
    assign o_cnt_existing    = cnt[CNT_EXISTING];
    assign o_cnt_new         = cnt[CNT_NEW];
    assign o_cnt_not_tracked = cnt[CNT_NOT_TRACKED];

endmodule : lookup_resolver

// ==== verilog/state_cache.sv ====
`timescale 1ns/1ps
`include "state_cache_cfg.svh"

module state_cache
    import state_cache_pkg::*;
(
    input  logic  clk,
    input  logic  htable_srst,

    input  logic  i_lookup_req,
    input  key_t  i_lookup_key,
    input  logic  i_delete_req,
    input  id_t   i_delete_id,
    input  logic  i_cnt_clear,

    output logic  o_lookup_rdy,
    output logic  o_lookup_ack,
    output logic  o_lookup_valid,
    output logic  o_lookup_new,
    output id_t   o_lookup_id,
    output logic  o_delete_rdy,
    output logic  o_init_done,
    output fill_t o_fill,
    output cnt_t  o_cnt_req,
    output cnt_t  o_cnt_existing,
    output cnt_t  o_cnt_new,
    output cnt_t  o_cnt_not_tracked
);

    logic         lookup_accept;
    logic         rd_ack;
    logic         rd_hit;
    id_t          rd_id;
    logic         ctxt_wr;
    lookup_ctxt_t ctxt_in;
    lookup_ctxt_t ctxt_out;
    logic         id_pop;
    logic         id_push;
    id_t          id_push_data;
    id_t          id_free;
    logic         id_empty;

    table_update_if upd_if ();

    // Ready once the table sweep is done
    assign o_init_done   = o_lookup_rdy;
    assign lookup_accept = i_lookup_req && o_lookup_rdy;

    key_table table0 (
        .clk          (clk),
        .htable_srst  (htable_srst),
        .i_lookup_req (i_lookup_req),
        .i_lookup_key (i_lookup_key),
        .o_lookup_rdy (o_lookup_rdy),
        .o_rd_ack     (rd_ack),
        .o_rd_hit     (rd_hit),
        .o_rd_id      (rd_id),
        .upd          (upd_if.tbl)
    );

    // Lookup context, popped with each read result
    sync_fifo #(
        .payload_t (lookup_ctxt_t),
        .DEPTH     (`STATE_CACHE_CTXT_DEPTH)
    ) ctxt_fifo0 (
        .clk         (clk),
        .htable_srst (htable_srst),
        .i_wr        (ctxt_wr),
        .i_wr_data   (ctxt_in),
        .i_rd        (rd_ack),
        .o_rd_data   (ctxt_out),
        .o_empty     ()
    );

    // Free ID pool
    sync_fifo #(
        .payload_t (id_t),
        .DEPTH     (2 ** `STATE_CACHE_ID_WID)
    ) id_fifo0 (
        .clk         (clk),
        .htable_srst (htable_srst),
        .i_wr        (id_push),
        .i_wr_data   (id_push_data),
        .i_rd        (id_pop),
        .o_rd_data   (id_free),
        .o_empty     (id_empty)
    );

    lookup_resolver resolver0 (
        .clk               (clk),
        .htable_srst       (htable_srst),
        .i_lookup_accept   (lookup_accept),
        .i_lookup_key      (i_lookup_key),
        .i_rd_ack          (rd_ack),
        .i_rd_hit          (rd_hit),
        .i_rd_id           (rd_id),
        .i_ctxt            (ctxt_out),
        .o_ctxt_wr         (ctxt_wr),
        .o_ctxt            (ctxt_in),
        .i_id_free         (id_free),
        .i_id_empty        (id_empty),
        .o_id_pop          (id_pop),
        .o_id_push         (id_push),
        .o_id_push_data    (id_push_data),
        .i_delete_req      (i_delete_req),
        .i_delete_id       (i_delete_id),
        .o_delete_rdy      (o_delete_rdy),
        .i_cnt_clear       (i_cnt_clear),
        .o_lookup_ack      (o_lookup_ack),
        .o_lookup_valid    (o_lookup_valid),
        .o_lookup_new      (o_lookup_new),
        .o_lookup_id       (o_lookup_id),
        .o_fill            (o_fill),
        .o_cnt_req         (o_cnt_req),
        .o_cnt_existing    (o_cnt_existing),
        .o_cnt_new         (o_cnt_new),
        .o_cnt_not_tracked (o_cnt_not_tracked),
        .upd               (upd_if.resolver)
    );

endmodule : state_cache

// ==== verilog/state_cache_cfg.svh ====
`ifndef STATE_CACHE_CFG_SVH
`define STATE_CACHE_CFG_SVH

// Lookup key width, one table entry per key
`define STATE_CACHE_KEY_WID 8

// Flow ID width, sets the size of the ID pool
`define STATE_CACHE_ID_WID 4

// Lookup context FIFO depth
`define STATE_CACHE_CTXT_DEPTH 4

// Statistics counter width
`define STATE_CACHE_CNT_WID 32

`endif

// ==== verilog/state_cache_pkg.sv ====
`include "state_cache_cfg.svh"

package state_cache_pkg;

    // ----------------------------------------
    // Basic types
    // ----------------------------------------
    typedef logic [`STATE_CACHE_KEY_WID-1:0] key_t;

    typedef logic [`STATE_CACHE_ID_WID-1:0] id_t;

    // Statistics counter
    typedef logic [`STATE_CACHE_CNT_WID-1:0] cnt_t;

    // Allocated ID count, one bit wider than an ID so a full pool fits
    typedef logic [`STATE_CACHE_ID_WID:0] fill_t;

    // ----------------------------------------
    // Lookup context
    // ----------------------------------------
    // Held from acceptance until the table result returns
    typedef struct packed {
        key_t key;
        logic back_to_back;
    } lookup_ctxt_t;

endpackage : state_cache_pkg

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     htable_srst,

    input  logic     i_wr,
    input  payload_t i_wr_data,

    input  logic     i_rd,
    output payload_t o_rd_data,
    output logic     o_empty
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               do_wr;
    logic               do_rd;

    // Pointer increment with wrap for any depth
    function automatic logic [PTR_WID-1:0] ptr_inc(input logic [PTR_WID-1:0] ptr);
        ptr_inc = (ptr == PTR_WID'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_rd = i_rd && !o_empty;
    // A full FIFO still takes a write when a read frees a slot
    assign do_wr = i_wr && ((count != CNT_WID'(DEPTH)) || do_rd);

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head of queue shown without a read
    assign o_rd_data = mem[rd_ptr];
    assign o_empty   = (count == '0);

endmodule : sync_fifo

// ==== verilog/table_update_if.sv ====
`timescale 1ns/1ps

interface table_update_if
    import state_cache_pkg::*;
();
    // Single-cycle write strobe
    logic upd_req;
    // Insert when high, delete when low
    logic upd_insert;
    // Key to insert, unused on delete
    key_t upd_key;
    id_t  upd_id;

    modport resolver (
        output upd_req,
        output upd_insert,
        output upd_key,
        output upd_id
    );

    // Key table side
    modport tbl (
        input upd_req,
        input upd_insert,
        input upd_key,
        input upd_id
    );

endinterface : table_update_if
